// File: eeprom_defs.svh
`ifndef EEPROM_DEFS_SVH
`define EEPROM_DEFS_SVH

// device type code, upper nibble of every control byte
`define EE_DEV_CODE 4'b1010

// 2 KB array, bits 10..8 ride in the control byte
`define EE_ADDR_W 11

`define EE_DATA_W 8

// CLK cycles per quarter of an SCL period, 1 or more
`define EE_QTR_CLKS 2

`endif

// File: eeprom_model.sv
`timescale 1ns/1ps
`default_nettype none
`include "eeprom_defs.svh"

module eeprom_model
(
    input  logic scl,
    inout  tri1  sda,
    input  logic refuse_ack  // withhold the control byte ack
);

    localparam int DEPTH = 1 << `EE_ADDR_W;

    localparam logic [2:0] M_IDLE   = 3'd0;
    localparam logic [2:0] M_CTRL   = 3'd1;
    localparam logic [2:0] M_ADDR   = 3'd2;
    localparam logic [2:0] M_DATA_W = 3'd3;
    localparam logic [2:0] M_DATA_R = 3'd4;

    logic [`EE_DATA_W-1:0] mem [0:DEPTH-1];
    logic [`EE_DATA_W-1:0] shreg;
    logic [`EE_ADDR_W-1:0] ptr;
    logic [2:0]            state;
    logic [3:0]            bitcnt;
    logic                  ack_phase;  // slave holds its ack for this slot
    logic                  pull_low;
    logic                  scl_prev;
    logic                  sda_prev;

    assign sda = pull_low ? 1'b0 : 1'bz;

    initial
    begin
        state     = M_IDLE;
        bitcnt    = 4'd0;
        ack_phase = 1'b0;
        pull_low  = 1'b0;
        scl_prev  = 1'b1;
        sda_prev  = 1'b1;
    end

    // a full byte has arrived, decide on the ack
    task automatic take_byte;
        logic ok;
        ok = 1'b1;
        case (state)
            M_CTRL:
                if (shreg[7:4] != `EE_DEV_CODE || refuse_ack)
                    ok = 1'b0;
                else
                begin
                    ptr[`EE_ADDR_W-1:8] = shreg[3:1];
                    if (shreg[0])
                    begin
                        shreg = mem[ptr];
                        state = M_DATA_R;
                    end
                    else
                        state = M_ADDR;
                end
            M_ADDR:
            begin
                ptr[7:0] = shreg;
                state    = M_DATA_W;
            end
            default:
            begin
                mem[ptr] = shreg;
                ptr      = ptr + 1'b1;
            end
        endcase
        if (ok)
        begin
            pull_low  = 1'b1;
            ack_phase = 1'b1;
        end
        else
            state = M_IDLE;
    endtask

    task automatic sample_bit;
        if (ack_phase)
            ;
        else if (state == M_DATA_R)
        begin
            if (bitcnt == 4'd8)
                state = M_IDLE;  // no sequential reads
            shreg  = {shreg[`EE_DATA_W-2:0], 1'b0};
            bitcnt = bitcnt + 4'd1;
        end
        else if (state != M_IDLE && bitcnt < 4'd8)
        begin
            shreg  = {shreg[`EE_DATA_W-2:0], sda};
            bitcnt = bitcnt + 4'd1;
        end
    endtask

    task automatic drive_bit;
        if (ack_phase)
        begin
            ack_phase = 1'b0;
            pull_low  = 1'b0;
            bitcnt    = 4'd0;
            if (state == M_DATA_R)
                pull_low = ~shreg[`EE_DATA_W-1];  // first read bit
        end
        else if (state == M_DATA_R)
            pull_low = (bitcnt < 4'd8) ? ~shreg[`EE_DATA_W-1] : 1'b0;
        else if (state != M_IDLE && bitcnt == 4'd8)
            take_byte();
    endtask

    always @(scl or sda)
    begin
        if (scl_prev === 1'b1 && scl === 1'b1 && sda_prev === 1'b1 && sda === 1'b0)
        begin
            state     = M_CTRL;  // start or repeated start
            bitcnt    = 4'd0;
            ack_phase = 1'b0;
        end
        else if (scl_prev === 1'b1 && scl === 1'b1 && sda_prev === 1'b0 && sda === 1'b1)
        begin
            state     = M_IDLE;
            ack_phase = 1'b0;
            pull_low  = 1'b0;
        end
        else if (scl_prev === 1'b0 && scl === 1'b1)
            sample_bit();
        else if (scl_prev === 1'b1 && scl === 1'b0)
            drive_bit();
        scl_prev = scl;
        sda_prev = sda;
    end

endmodule

`default_nettype wire

// File: eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    // operation handed from the sequencer to the bit engine
    // OP_START doubles as the repeated start
    typedef enum logic [1:0] {
        OP_START = 2'd0,
        OP_STOP  = 2'd1,
        OP_WRITE = 2'd2,  // 8 data bits out, ack bit in
        OP_READ  = 2'd3   // 8 data bits in, ack bit out
    } bit_op_t;

endpackage

`default_nettype wire

// File: eeprom_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "eeprom_defs.svh"

module eeprom_sequencer
    import eeprom_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  logic [`EE_ADDR_W-1:0] addr,
    input  logic [`EE_DATA_W-1:0] wdata,
    output logic [`EE_DATA_W-1:0] rdata,
    output logic                  busy,
    output logic                  done,
    output logic                  nack,
    output logic                  op_valid,
    output bit_op_t               op,
    output logic [`EE_DATA_W-1:0] tx_byte,
    output logic                  master_ack,
    input  logic                  op_done,
    input  logic [`EE_DATA_W-1:0] rx_byte,
    input  logic                  slave_ack
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR,
        S_DATA_W,
        S_RESTART,
        S_CTRL_R,
        S_DATA_R,
        S_STOP,
        S_FINISH
    } state_t;

    state_t                state;
    state_t                state_n;
    logic [`EE_ADDR_W-1:0] addr_q;
    logic [`EE_DATA_W-1:0] wdata_q;
    logic [`EE_DATA_W-1:0] rx_hold;
    logic                  rd_q;
    logic                  accept;
    logic                  ack_state;  // states that expect a slave ack

    function automatic bit_op_t op_of(input state_t s);
        case (s)
            S_START, S_RESTART: return OP_START;
            S_STOP:             return OP_STOP;
            S_DATA_R:           return OP_READ;
            default:            return OP_WRITE;
        endcase
    endfunction

    function automatic logic needs_op(input state_t s);
        return !(s inside {S_IDLE, S_FINISH});
    endfunction

    function automatic logic [`EE_DATA_W-1:0] byte_of(input state_t s);
        case (s)
            S_CTRL_W: return {`EE_DEV_CODE, addr_q[`EE_ADDR_W-1:8], 1'b0};
            S_ADDR:   return addr_q[7:0];
            S_CTRL_R: return {`EE_DEV_CODE, addr_q[`EE_ADDR_W-1:8], 1'b1};
            default:  return wdata_q;
        endcase
    endfunction

    assign accept     = (state == S_IDLE) && (wr || rd);
    assign ack_state  = state inside {S_CTRL_W, S_ADDR, S_DATA_W, S_CTRL_R};
    assign busy       = (state != S_IDLE);
    assign master_ack = 1'b1;  // single byte read ends in nack

    always_comb
    begin
        state_n = state;
        case (state)
            S_IDLE:
                if (wr || rd)
                    state_n = S_START;
            S_START:
                if (op_done)
                    state_n = S_CTRL_W;
            S_CTRL_W:
                if (op_done)
                    state_n = slave_ack ? S_STOP : S_ADDR;
            S_ADDR:
                if (op_done)
                begin
                    if (slave_ack)
                        state_n = S_STOP;
                    else
                        state_n = rd_q ? S_RESTART : S_DATA_W;
                end
            S_DATA_W:
                if (op_done)
                    state_n = S_STOP;
            S_RESTART:
                if (op_done)
                    state_n = S_CTRL_R;
            S_CTRL_R:
                if (op_done)
                    state_n = slave_ack ? S_STOP : S_DATA_R;
            S_DATA_R:
                if (op_done)
                    state_n = S_STOP;
            S_STOP:
                if (op_done)
                    state_n = S_FINISH;
            default:
                state_n = S_IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= S_IDLE;
            op_valid <= 1'b0;
            done     <= 1'b0;
            nack     <= 1'b0;
        end
        else
        begin
            state    <= state_n;
            op_valid <= (state_n != state) && needs_op(state_n);  // one op per state
            done     <= (state == S_STOP) && op_done;
            if (accept)
                nack <= 1'b0;
            else if (op_done && ack_state && slave_ack)
                nack <= 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            addr_q  <= addr;
            wdata_q <= wdata;
            rd_q    <= !wr;  // write wins a tie
        end
        if (state_n != state)
        begin
            op      <= op_of(state_n);
            tx_byte <= byte_of(state_n);
        end
        if (state == S_DATA_R && op_done)
            rx_hold <= rx_byte;
        if (state == S_STOP && op_done && rd_q && !nack)
            rdata <= rx_hold;  // lands with done
    end

    // engine has no back-pressure, one op in flight at a time
    a_op_spacing: assert property (@(posedge CLK) disable iff (RESET)
        op_valid |=> (!op_valid until op_done));

    a_done_idle_engine: assert property (@(posedge CLK) disable iff (RESET)
        !(done && op_valid));

endmodule

`default_nettype wire

// File: eeprom_wr.sv
`timescale 1ns/1ps
`default_nettype none
`include "eeprom_defs.svh"

module eeprom_wr
    import eeprom_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  logic [`EE_ADDR_W-1:0] addr,
    input  logic [`EE_DATA_W-1:0] wdata,
    output logic [`EE_DATA_W-1:0] rdata,
    output logic                  busy,
    output logic                  done,
    output logic                  nack,
    output logic                  scl,
    inout  tri1                   sda   // pulled up when released
);

    logic                  op_valid;
    bit_op_t               op;
    logic [`EE_DATA_W-1:0] tx_byte;
    logic [`EE_DATA_W-1:0] rx_byte;
    logic                  master_ack;
    logic                  op_done;
    logic                  slave_ack;
    logic                  sda_low;

    // open drain, never drives high
    assign sda = sda_low ? 1'b0 : 1'bz;

    eeprom_sequencer u_seq (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .addr       (addr),
        .wdata      (wdata),
        .rdata      (rdata),
        .busy       (busy),
        .done       (done),
        .nack       (nack),
        .op_valid   (op_valid),
        .op         (op),
        .tx_byte    (tx_byte),
        .master_ack (master_ack),
        .op_done    (op_done),
        .rx_byte    (rx_byte),
        .slave_ack  (slave_ack)
    );

    i2c_bit_engine u_bits (
        .CLK        (CLK),
        .RESET      (RESET),
        .op_valid   (op_valid),
        .op         (op),
        .tx_byte    (tx_byte),
        .master_ack (master_ack),
        .op_done    (op_done),
        .rx_byte    (rx_byte),
        .slave_ack  (slave_ack),
        .scl        (scl),
        .sda_low    (sda_low),
        .sda_in     (sda)
    );

endmodule

`default_nettype wire

// File: i2c_bit_engine.sv
`timescale 1ns/1ps
`default_nettype none
`include "eeprom_defs.svh"

module i2c_bit_engine
    import eeprom_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  op_valid,
    input  bit_op_t               op,
    input  logic [`EE_DATA_W-1:0] tx_byte,
    input  logic                  master_ack,
    output logic                  op_done,
    output logic [`EE_DATA_W-1:0] rx_byte,
    output logic                  slave_ack,
    output logic                  scl,
    output logic                  sda_low,
    input  logic                  sda_in
);

    localparam int QW = (`EE_QTR_CLKS > 1) ? $clog2(`EE_QTR_CLKS) : 1;
    localparam logic [3:0] ACK_BIT = 4'(`EE_DATA_W);  // ninth slot of a byte

    logic                  run;
    logic [QW-1:0]         qcnt;
    logic [1:0]            q;       // quarter index within the slot
    logic [3:0]            bitcnt;
    logic [`EE_DATA_W-1:0] shift_q;
    logic                  mack_q;
    bit_op_t               op_q;
    bit_op_t               op_c;
    logic                  qend;
    logic                  last_slot;
    logic                  finish;
    logic                  step;    // entering a new quarter
    logic [1:0]            nq;
    logic [3:0]            nb;
    logic                  scl_n;
    logic                  sda_n;

    assign op_c      = run ? op_q : op;
    assign qend      = (qcnt == QW'(`EE_QTR_CLKS - 1));
    assign last_slot = (op_q == OP_WRITE || op_q == OP_READ) ? (bitcnt == ACK_BIT)
                                                             : (bitcnt == 4'd0);
    assign finish    = run && qend && (q == 2'd3) && last_slot;
    assign rx_byte   = shift_q;

    always_comb
    begin
        step = 1'b0;
        nq   = q;
        nb   = bitcnt;
        if (op_valid && !run)
        begin
            step = 1'b1;
            nq   = 2'd0;
            nb   = 4'd0;
        end
        else if (run && qend && !finish)
        begin
            step = 1'b1;
            if (q == 2'd3)
            begin
                nq = 2'd0;
                nb = bitcnt + 4'd1;
            end
            else
                nq = q + 2'd1;
        end
    end

    // line levels for the quarter being entered
    always_comb
    begin
        scl_n = nq[1];
        sda_n = sda_low;
        case (op_c)
            OP_START:
            begin
                scl_n = (nq != 2'd0);
                if (nq == 2'd0)
                    sda_n = 1'b0;      // release while scl low
                else if (nq == 2'd2)
                    sda_n = 1'b1;      // falling sda, scl high
            end
            OP_STOP:
            begin
                if (nq == 2'd1)
                    sda_n = 1'b1;
                else if (nq == 2'd3)
                    sda_n = 1'b0;      // rising sda, scl high
            end
            OP_WRITE:
                if (nq == 2'd1)
                    sda_n = (nb == ACK_BIT) ? 1'b0 : ~shift_q[`EE_DATA_W-1];
            default:
                if (nq == 2'd1)
                    sda_n = (nb == ACK_BIT) ? ~mack_q : 1'b0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            run     <= 1'b0;
            qcnt    <= '0;
            q       <= 2'd0;
            bitcnt  <= 4'd0;
            op_q    <= OP_STOP;
            op_done <= 1'b0;
            scl     <= 1'b1;
            sda_low <= 1'b0;
        end
        else
        begin
            op_done <= finish;
            if (op_valid && !run)
            begin
                run  <= 1'b1;
                op_q <= op;
            end
            else if (finish)
                run <= 1'b0;

            if (run && !qend)
                qcnt <= qcnt + 1'b1;
            else
                qcnt <= '0;

            if (step)
            begin
                q       <= nq;
                bitcnt  <= nb;
                scl     <= scl_n;
                sda_low <= sda_n;
            end
        end
    end

    // data path, msb first
    always_ff @(posedge CLK)
    begin
        if (op_valid && !run)
        begin
            shift_q <= tx_byte;
            mack_q  <= master_ack;
        end
        else if (step)
        begin
            if (op_q == OP_WRITE && nq == 2'd1 && nb != ACK_BIT)
                shift_q <= {shift_q[`EE_DATA_W-2:0], 1'b0};
            if (op_q == OP_READ && nq == 2'd2 && nb != ACK_BIT)
                shift_q <= {shift_q[`EE_DATA_W-2:0], sda_in};
            if (op_q == OP_WRITE && nq == 2'd2 && nb == ACK_BIT)
                slave_ack <= sda_in;   // high means no ack
        end
    end

    // data may only move under a high clock for start and stop conditions
    a_sda_under_scl: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && $changed(sda_low)) |-> (op_q inside {OP_START, OP_STOP}));

    a_no_overlap: assert property (@(posedge CLK) disable iff (RESET)
        op_valid |-> !run);

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
eeprom_pkg.sv
i2c_bit_engine.sv
eeprom_sequencer.sv
eeprom_wr.sv
eeprom_model.sv
tb_eeprom_wr.sv

// File: tb_eeprom_wr.sv
`timescale 1ns/1ps
`default_nettype none
`include "eeprom_defs.svh"

module tb_eeprom_wr;

    localparam int SLOT_CLKS = 4 * `EE_QTR_CLKS;
    localparam int MAX_WAIT  = 48 * SLOT_CLKS + 64;  // a read is the longest sequence
    localparam int DEPTH     = 1 << `EE_ADDR_W;

    logic                  CLK;
    logic                  RESET;
    logic                  wr;
    logic                  rd;
    logic [`EE_ADDR_W-1:0] addr;
    logic [`EE_DATA_W-1:0] wdata;
    logic [`EE_DATA_W-1:0] rdata;
    logic                  busy;
    logic                  done;
    logic                  nack;
    logic                  scl;
    tri1                   sda;
    logic                  refuse_ack;

    logic [`EE_DATA_W-1:0] ref_mem [0:DEPTH-1];
    integer                seed;
    int                    pass_cnt;
    int                    fail_cnt;
    int                    errs;
    string                 test_name;
    logic [`EE_DATA_W-1:0] got_data;
    logic                  got_nack;

    initial
    begin
        CLK = 1'b0;
        forever
            #20 CLK = ~CLK;
    end

    eeprom_wr u_dut (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .busy  (busy),
        .done  (done),
        .nack  (nack),
        .scl   (scl),
        .sda   (sda)
    );

    eeprom_model u_mem (
        .scl        (scl),
        .sda        (sda),
        .refuse_ack (refuse_ack)
    );

    function automatic logic [`EE_DATA_W-1:0] fill_value(input logic [`EE_ADDR_W-1:0] a);
        return a[7:0] ^ {a[`EE_ADDR_W-1:8], 5'b10110};
    endfunction

    task automatic preload;
        for (int i = 0; i < DEPTH; i++)
        begin
            ref_mem[i]   = fill_value(i[`EE_ADDR_W-1:0]);
            u_mem.mem[i] = ref_mem[i];
        end
    endtask

    task automatic compare(input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("Error: %s expected %0h actual %0h", test_name, expected, actual);
            errs++;
        end
    endtask

    task automatic abort(input string msg);
        $display("%s in test %s", msg, test_name);
        $display("Result: FAILED");
        $finish;
    endtask

    task automatic end_test;
        if (errs == 0)
        begin
            $display("test %s: ok", test_name);
            pass_cnt++;
        end
        else
        begin
            $display("test %s: %0d errors", test_name, errs);
            fail_cnt++;
        end
        errs = 0;
    endtask

    task automatic strobe(input logic w, input logic r, input logic [`EE_ADDR_W-1:0] a,
                          input logic [`EE_DATA_W-1:0] d);
        @(posedge CLK);
        wr    <= w;
        rd    <= r;
        addr  <= a;
        wdata <= d;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
    endtask

    // done is sampled mid-cycle and the bus checked one cycle later
    task automatic wait_done;
        int n;
        n = 0;
        @(negedge CLK);
        while (!done && n < MAX_WAIT)
        begin
            @(negedge CLK);
            n++;
        end
        if (!done)
            abort("the DUT never raised done");
        else
        begin
            got_data = rdata;
            got_nack = nack;
            @(negedge CLK);
            compare(2'b11, {scl, sda});  // stop left the bus released
        end
    endtask

    task automatic do_write(input logic [`EE_ADDR_W-1:0] a, input logic [`EE_DATA_W-1:0] d,
                            input logic exp_nack);
        strobe(1'b1, 1'b0, a, d);
        wait_done();
        compare(exp_nack, got_nack);
        if (!exp_nack)
            ref_mem[a] = d;
    endtask

    task automatic do_read(input logic [`EE_ADDR_W-1:0] a, input logic exp_nack);
        strobe(1'b0, 1'b1, a, '0);
        wait_done();
        compare(exp_nack, got_nack);
        if (!exp_nack)
            compare(ref_mem[a], got_data);
    endtask

    task automatic set_refuse(input logic v);
        @(posedge CLK);
        refuse_ack <= v;
    endtask

    initial
    begin
        logic [31:0]           rnd;
        logic [`EE_ADDR_W-1:0] a;
        logic [`EE_ADDR_W-1:0] a2;
        logic [`EE_DATA_W-1:0] d;
        logic [`EE_ADDR_W-1:0] written [$];
        seed       = 47;
        pass_cnt   = 0;
        fail_cnt   = 0;
        errs       = 0;
        RESET      = 1'b1;
        wr         = 1'b0;
        rd         = 1'b0;
        addr       = '0;
        wdata      = '0;
        refuse_ack = 1'b0;
        preload();
        repeat (2) @(posedge CLK);
        RESET <= 1'b0;

        test_name = "reset_state";
        @(negedge CLK);
        compare(3'b000, {busy, done, nack});
        compare(2'b11, {scl, sda});
        end_test();

        test_name = "write_read";
        rnd = $random(seed);
        a   = rnd[`EE_ADDR_W-1:0];
        d   = rnd[`EE_ADDR_W+`EE_DATA_W-1:`EE_ADDR_W];
        do_write(a, d, 1'b0);
        do_read(a, 1'b0);
        compare(d, got_data);
        end_test();

        test_name = "random_traffic";
        for (int i = 0; i < 40; i++)
        begin
            rnd = $random(seed);
            a   = {i[2:0], rnd[7:0]};  // every block code gets used
            if (rnd[8])
            begin
                do_write(a, rnd[16:9], 1'b0);
                written.push_back(a);
            end
            else
                do_read(a, 1'b0);
        end
        for (int k = 0; k < written.size(); k++)
            do_read(written[k], 1'b0);  // each write lands in the slave
        end_test();

        test_name = "busy_strobes";
        rnd = $random(seed);
        a   = rnd[`EE_ADDR_W-1:0];
        a2  = a ^ 11'h2a5;
        d   = rnd[19:12];
        strobe(1'b1, 1'b0, a, d);
        repeat (3) @(negedge CLK);
        compare(1'b1, busy);
        strobe(1'b1, 1'b0, a2, ~ref_mem[a2]);
        strobe(1'b0, 1'b1, a2, '0);
        wait_done();
        compare(1'b0, got_nack);
        ref_mem[a] = d;
        for (int n = 0; n < 2 * SLOT_CLKS + 4; n++)
        begin
            @(negedge CLK);
            compare(2'b00, {done, busy});
        end
        do_read(a, 1'b0);
        do_read(a2, 1'b0);
        end_test();

        test_name = "missing_ack";
        rnd = $random(seed);
        a   = rnd[`EE_ADDR_W-1:0];
        set_refuse(1'b1);
        do_write(a, ~ref_mem[a], 1'b1);
        set_refuse(1'b0);
        do_read(a, 1'b0);
        set_refuse(1'b1);
        do_read(a, 1'b1);
        set_refuse(1'b0);
        end_test();

        $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire
